//--- build.f
hdl/lc3b_types.sv
hdl/array.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/cache.sv
verification/clock_gen.sv
verification/line_memory.sv
verification/cache_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cache_tb
FILELIST  = build.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/cache_tb.sv
module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lc3b_types::*;

  localparam int SEED       = 32'h1c54f30f;
  localparam int NUM_RANDOM = 300;
  // worst access: compare, writeback, fill, final hit, plus idle cycle
  localparam int OP_CYCLES  = 2 * (MEM_DELAY + 1) + 3;
  localparam int NUM_OPS    = 40 + NUM_RANDOM + 2 * CACHE_SETS;
  localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES + 100;

  logic          clk;
  logic          reset;
  lc3b_word      mem_address;
  logic          mem_read;
  logic          mem_write;
  lc3b_word      mem_wdata;
  lc3b_mem_wmask mem_byte_enable;
  lc3b_word      mem_rdata;
  logic          mem_resp;
  lc3b_word      pmem_address;
  logic          pmem_read;
  logic          pmem_write;
  lc3b_c_line    pmem_wdata;
  lc3b_c_line    pmem_rdata;
  logic          pmem_resp;
  int            read_count;
  int            write_count;
  lc3b_word      last_write_address;

  // word-level reference copy of memory
  lc3b_word ref_mem [32768];
  int       reads_mark;
  int       writes_mark;
  int       cycle_count = 0;

  clock_gen i_clock (.clk(clk), .reset(reset));

  cache i_dut (
    .clk(clk), .reset(reset), .mem_address(mem_address), .mem_read(mem_read),
    .mem_write(mem_write), .mem_wdata(mem_wdata), .mem_byte_enable(mem_byte_enable),
    .mem_rdata(mem_rdata), .mem_resp(mem_resp), .pmem_address(pmem_address),
    .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_wdata(pmem_wdata),
    .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
  );

  line_memory i_mem (
    .clk(clk), .reset(reset), .pmem_address(pmem_address), .pmem_read(pmem_read),
    .pmem_write(pmem_write), .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata),
    .pmem_resp(pmem_resp), .read_count(read_count), .write_count(write_count),
    .last_write_address(last_write_address)
  );

  // ------------------------------
  // checking helpers
  // ------------------------------
  task automatic report_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string name, lc3b_word got, lc3b_word expected);
    assert (got === expected) else begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, expected);
      report_failure();
    end
  endtask

  task automatic verify_count(string name, int got, int expected);
    assert (got == expected) else begin
      $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
      report_failure();
    end
  endtask

  task automatic mark_traffic();
    reads_mark  = read_count;
    writes_mark = write_count;
  endtask

  task automatic expect_traffic(int reads, int writes);
    verify_count("read_count delta", read_count - reads_mark, reads);
    verify_count("write_count delta", write_count - writes_mark, writes);
    mark_traffic();
  endtask

  task automatic compare_line(lc3b_word addr);
    for (int w = 0; w < 8; w++) begin
      check_word($sformatf("i_mem.mem[%h].words[%0d]", addr[15:4], w),
                 i_mem.mem[addr[15:4]].words[w], ref_mem[{addr[15:4], 3'(w)}]);
    end
  endtask

  function automatic lc3b_word make_address(logic [TAG_WIDTH-1:0] tag,
                                            logic [INDEX_WIDTH-1:0] index, logic [2:0] word);
    return {tag, index, word, 1'b0};
  endfunction

  function automatic void model_write(lc3b_word addr, lc3b_word data, lc3b_mem_wmask be);
    if (be[0]) begin
      ref_mem[addr[15:1]][7:0] = data[7:0];
    end
    if (be[1]) begin
      ref_mem[addr[15:1]][15:8] = data[15:8];
    end
  endfunction

  // ------------------------------
  // processor side access
  // ------------------------------
  task automatic bus_access(logic is_write, lc3b_word addr, lc3b_word data,
                            lc3b_mem_wmask be, output lc3b_word rdata);
    @(negedge clk);
    mem_address     = addr;
    mem_read        = !is_write;
    mem_write       = is_write;
    mem_wdata       = data;
    mem_byte_enable = be;
    // the response settles in the low half of the clock and is taken there
    #1;
    while (!mem_resp) begin
      @(negedge clk);
      #1;
    end
    rdata = mem_rdata;
    @(negedge clk);
    mem_read  = 1'b0;
    mem_write = 1'b0;
  endtask

  task automatic read_word(lc3b_word addr);
    lc3b_word data;
    bus_access(1'b0, addr, 16'h0000, 2'b00, data);
    check_word("mem_rdata", data, ref_mem[addr[15:1]]);
  endtask

  task automatic write_word(lc3b_word addr, lc3b_word data, lc3b_mem_wmask be);
    lc3b_word unused;
    bus_access(1'b1, addr, data, be, unused);
    model_write(addr, data, be);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic read_miss_then_hit();
    mark_traffic();
    read_word(make_address(9'd1, 3'd0, 3'd3));
    expect_traffic(1, 0);
    read_word(make_address(9'd1, 3'd0, 3'd5));
    expect_traffic(0, 0);
  endtask

  task automatic byte_enable_writes();
    lc3b_word addr = make_address(9'd2, 3'd1, 3'd6);
    read_word(addr);
    mark_traffic();
    for (int be = 0; be < 4; be++) begin
      write_word(addr, lc3b_word'($urandom), lc3b_mem_wmask'(be));
      read_word(addr);
    end
    expect_traffic(0, 0);
  endtask

  task automatic dirty_eviction();
    lc3b_word a = make_address(9'd3, 3'd2, 3'd0);
    lc3b_word b = make_address(9'd4, 3'd2, 3'd1);
    write_word(a, 16'hbeef, 2'b11);
    write_word(b, 16'hcafe, 2'b01);
    mark_traffic();
    read_word(make_address(9'd5, 3'd2, 3'd2));
    expect_traffic(1, 1);
    check_word("last_write_address", last_write_address, a);
    compare_line(a);
  endtask

  task automatic lru_victim_choice();
    lc3b_word a = make_address(9'd6, 3'd3, 3'd0);
    lc3b_word b = make_address(9'd7, 3'd3, 3'd0);
    // both dirty, so only the LRU bit decides which one goes out
    write_word(a, 16'h0f0f, 2'b11);
    write_word(b, 16'hf0f0, 2'b11);
    read_word(a);
    mark_traffic();
    read_word(make_address(9'd8, 3'd3, 3'd4));
    expect_traffic(1, 1);
    check_word("pmem_address", last_write_address, b);
    read_word(a);
    expect_traffic(0, 0);
  endtask

  task automatic clean_eviction();
    mark_traffic();
    for (int t = 10; t < 13; t++) begin
      read_word(make_address(9'(t), 3'd4, 3'(t)));
    end
    expect_traffic(3, 0);
  endtask

  task automatic random_traffic();
    lc3b_word      addr;
    lc3b_word      data;
    lc3b_mem_wmask be;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      // tags 20 to 23 over all sets and words
      addr = 16'h0a00 + lc3b_word'(2 * $urandom_range(0, 255));
      data = lc3b_word'($urandom);
      be   = lc3b_mem_wmask'($urandom_range(0, 3));
      if ($urandom_range(0, 1) == 1) begin
        write_word(addr, data, be);
      end else begin
        read_word(addr);
      end
    end
    // two unused tags per set push every dirty line out to memory
    for (int s = 0; s < CACHE_SETS; s++) begin
      read_word(make_address(9'd500, 3'(s), 3'd0));
      read_word(make_address(9'd501, 3'(s), 3'd0));
    end
    for (int l = 0; l < 4096; l++) begin
      compare_line(lc3b_word'(l * 16));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      report_failure();
    end
  end

  initial begin
    void'($urandom(SEED));
    mem_address     = '0;
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    mem_wdata       = '0;
    mem_byte_enable = '0;
    reads_mark      = 0;
    writes_mark     = 0;
    for (int i = 0; i < 32768; i++) begin
      ref_mem[i] = lc3b_word'(2 * i) ^ 16'h5a5a;
    end
    @(negedge reset);
    read_miss_then_hit();
    byte_enable_writes();
    dirty_eviction();
    lru_victim_choice();
    clean_eviction();
    random_traffic();
    $display("TEST PASSED");
    $finish;
  end

endmodule : cache_tb

//--- verification/line_memory.sv
module line_memory (
  input  logic                   clk,
  input  logic                   reset,
  input  lc3b_types::lc3b_word   pmem_address,
  input  logic                   pmem_read,
  input  logic                   pmem_write,
  input  lc3b_types::lc3b_c_line pmem_wdata,
  output lc3b_types::lc3b_c_line pmem_rdata,
  output logic                   pmem_resp,
  output int                     read_count,
  output int                     write_count,
  output lc3b_types::lc3b_word   last_write_address
);
  timeunit 1ns;
  timeprecision 1ps;
  import lc3b_types::*;

  localparam int LINES = 4096;

  lc3b_c_line mem [LINES];
  int         delay_count;

  // every word holds its own byte address xor 5a5a
  function automatic lc3b_c_line pattern_line(int line);
    lc3b_c_line value;
    for (int w = 0; w < 8; w++) begin
      value.words[w] = lc3b_word'(line * 16 + w * 2) ^ 16'h5a5a;
    end
    return value;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < LINES; l++) begin
        mem[l] <= pattern_line(l);
      end
      pmem_rdata         <= '0;
      pmem_resp          <= 1'b0;
      delay_count        <= 0;
      read_count         <= 0;
      write_count        <= 0;
      last_write_address <= '0;
    end else if ((pmem_read || pmem_write) && !pmem_resp) begin
      if (delay_count == MEM_DELAY - 1) begin
        delay_count <= 0;
        pmem_resp   <= 1'b1;
        if (pmem_write) begin
          mem[pmem_address[15:4]] <= pmem_wdata;
          write_count             <= write_count + 1;
          last_write_address      <= pmem_address;
        end else begin
          pmem_rdata <= mem[pmem_address[15:4]];
          read_count <= read_count + 1;
        end
      end else begin
        delay_count <= delay_count + 1;
      end
    end else begin
      // response is a single cycle pulse
      pmem_resp <= 1'b0;
    end
  end

endmodule : line_memory

//--- verification/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release on a falling edge, like every other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule : clock_gen

//--- hdl/cache.sv
module cache (
  input  logic                      clk,
  input  logic                      reset,

  // processor side
  input  lc3b_types::lc3b_word      mem_address,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  lc3b_types::lc3b_word      mem_wdata,
  input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
  output lc3b_types::lc3b_word      mem_rdata,
  output logic                      mem_resp,

  // memory side
  output lc3b_types::lc3b_word      pmem_address,
  output logic                      pmem_read,
  output logic                      pmem_write,
  output lc3b_types::lc3b_c_line    pmem_wdata,
  input  lc3b_types::lc3b_c_line    pmem_rdata,
  input  logic                      pmem_resp
);

  logic write_enable;
  logic control_load;
  logic lru_load;
  logic address_sel;
  logic hit;
  logic dirty;

  cache_datapath datapath (
    .clk             (clk),
    .reset           (reset),
    .address         (mem_address),
    .mem_wdata       (mem_wdata),
    .mem_byte_enable (mem_byte_enable),
    .pmem_rdata      (pmem_rdata),
    .write_enable    (write_enable),
    .control_load    (control_load),
    .lru_load        (lru_load),
    .address_sel     (address_sel),
    .hit             (hit),
    .dirty           (dirty),
    .mem_rdata       (mem_rdata),
    .pmem_wdata      (pmem_wdata),
    .pmem_address    (pmem_address)
  );

  cache_control control (
    .clk          (clk),
    .reset        (reset),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .hit          (hit),
    .dirty        (dirty),
    .write_enable (write_enable),
    .control_load (control_load),
    .lru_load     (lru_load),
    .address_sel  (address_sel),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp)
  );

endmodule : cache

//--- hdl/cache_control.sv
module cache_control (
  input  logic clk,
  input  logic reset,
  input  logic mem_read,
  input  logic mem_write,
  input  logic hit,
  input  logic dirty,
  output logic write_enable,
  output logic control_load,
  output logic lru_load,
  output logic address_sel,
  output logic mem_resp,
  output logic pmem_read,
  output logic pmem_write,
  input  logic pmem_resp
);
  import lc3b_types::*;

  logic [1:0] state;
  logic [1:0] next_state;
  logic       request;

  assign request = mem_read | mem_write;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CTRL_COMPARE;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    next_state = state;
    case (state)
      CTRL_COMPARE: begin
        if (request && !hit) begin
          // dirty victim must reach memory before the fill overwrites it
          if (dirty) begin
            next_state = CTRL_WRITEBACK;
          end else begin
            next_state = CTRL_ALLOCATE;
          end
        end
      end
      CTRL_WRITEBACK: begin
        if (pmem_resp) begin
          next_state = CTRL_ALLOCATE;
        end
      end
      CTRL_ALLOCATE: begin
        if (pmem_resp) begin
          next_state = CTRL_COMPARE;
        end
      end
      default: begin
        next_state = CTRL_COMPARE;
      end
    endcase
  end

  // ------------------------------
  // outputs
  // ------------------------------
  always_comb begin
    write_enable = 1'b0;
    control_load = 1'b0;
    lru_load     = 1'b0;
    address_sel  = 1'b0;
    mem_resp     = 1'b0;
    pmem_read    = 1'b0;
    pmem_write   = 1'b0;
    case (state)
      CTRL_COMPARE: begin
        if (request && hit) begin
          mem_resp     = 1'b1;
          lru_load     = 1'b1;
          write_enable = mem_write;
        end
      end
      CTRL_WRITEBACK: begin
        pmem_write  = 1'b1;
        address_sel = 1'b1;
      end
      CTRL_ALLOCATE: begin
        pmem_read = 1'b1;
        // line is stored at the same edge the memory answers
        control_load = pmem_resp;
      end
      default: begin
        mem_resp = 1'b0;
      end
    endcase
  end

  // one memory transfer direction at a time
  assert property (@(posedge clk) disable iff (reset) !(pmem_read && pmem_write));

  // the cycle after a fill the request hits and completes
  assert property (@(posedge clk) disable iff (reset)
    control_load |=> (hit && mem_resp));

endmodule : cache_control

//--- hdl/cache_datapath.sv
module cache_datapath (
  input  logic                      clk,
  input  logic                      reset,
  input  lc3b_types::lc3b_word      address,
  input  lc3b_types::lc3b_word      mem_wdata,
  input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
  input  lc3b_types::lc3b_c_line    pmem_rdata,
  input  logic                      write_enable,
  input  logic                      control_load,
  input  logic                      lru_load,
  input  logic                      address_sel,
  output logic                      hit,
  output logic                      dirty,
  output lc3b_types::lc3b_word      mem_rdata,
  output lc3b_types::lc3b_c_line    pmem_wdata,
  output lc3b_types::lc3b_word      pmem_address
);
  import lc3b_types::*;

  logic [INDEX_WIDTH-1:0]    index;
  logic [TAG_WIDTH-1:0]      tag;
  logic [OFFSET_WIDTH-2:0]   word_sel;
  logic [TAG_WIDTH:0]        valid_tag_in;
  logic [TAG_WIDTH:0]        valid_tag1_out;
  logic [TAG_WIDTH:0]        valid_tag2_out;
  logic [TAG_WIDTH-1:0]      victim_tag_in;
  logic [TAG_WIDTH-1:0]      victim_tag_out;
  logic                      hit1;
  logic                      hit2;
  logic                      lru_out;
  logic                      dirty1_out;
  logic                      dirty2_out;
  logic                      dirty_in;
  logic                      fill1;
  logic                      fill2;
  logic                      data1_write;
  logic                      data2_write;
  lc3b_c_line                data1_out;
  lc3b_c_line                data2_out;
  lc3b_c_line                hit_line;
  lc3b_c_line                merge_line;
  lc3b_c_line                line_in;

  assign index    = address[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag      = address[OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
  assign word_sel = address[OFFSET_WIDTH-1:1];

  // ------------------------------
  // hit detection
  // ------------------------------
  assign valid_tag_in = {1'b1, tag};
  assign hit1 = (valid_tag1_out == valid_tag_in);
  assign hit2 = (valid_tag2_out == valid_tag_in);
  assign hit  = hit1 | hit2;

  assign hit_line  = hit1 ? data1_out : data2_out;
  assign mem_rdata = hit_line.words[word_sel];

  // byte merge of the processor write into the hit line
  always_comb begin
    merge_line = hit_line;
    if (mem_byte_enable[0]) begin
      merge_line.words[word_sel][7:0] = mem_wdata[7:0];
    end
    if (mem_byte_enable[1]) begin
      merge_line.words[word_sel][15:8] = mem_wdata[15:8];
    end
  end

  // ------------------------------
  // array write control
  // ------------------------------
  // lru_out names the victim, 0 for way 1 and 1 for way 2
  assign fill1 = control_load & ~lru_out;
  assign fill2 = control_load &  lru_out;

  assign data1_write = fill1 | (write_enable & hit1);
  assign data2_write = fill2 | (write_enable & hit2);

  assign line_in  = control_load ? pmem_rdata : merge_line;
  // a fill brings a clean line, a write hit makes it dirty
  assign dirty_in = ~control_load;

  // tag of the way that becomes least recently used after this access
  assign victim_tag_in = hit1 ? valid_tag2_out[TAG_WIDTH-1:0] : valid_tag1_out[TAG_WIDTH-1:0];

  array #(.width(1)) lru (
    .clk     (clk),
    .reset   (reset),
    .write   (lru_load),
    .index   (index),
    .datain  (hit1),
    .dataout (lru_out)
  );

  array #(.width(128)) data1 (
    .clk     (clk),
    .reset   (1'b0),
    .write   (data1_write),
    .index   (index),
    .datain  (line_in.bits),
    .dataout (data1_out)
  );

  array #(.width(128)) data2 (
    .clk     (clk),
    .reset   (1'b0),
    .write   (data2_write),
    .index   (index),
    .datain  (line_in.bits),
    .dataout (data2_out)
  );

  array #(.width(TAG_WIDTH + 1)) valid_tag1 (
    .clk     (clk),
    .reset   (reset),
    .write   (fill1),
    .index   (index),
    .datain  (valid_tag_in),
    .dataout (valid_tag1_out)
  );

  array #(.width(TAG_WIDTH + 1)) valid_tag2 (
    .clk     (clk),
    .reset   (reset),
    .write   (fill2),
    .index   (index),
    .datain  (valid_tag_in),
    .dataout (valid_tag2_out)
  );

  array #(.width(1)) dirty1 (
    .clk     (clk),
    .reset   (reset),
    .write   (data1_write),
    .index   (index),
    .datain  (dirty_in),
    .dataout (dirty1_out)
  );

  array #(.width(1)) dirty2 (
    .clk     (clk),
    .reset   (reset),
    .write   (data2_write),
    .index   (index),
    .datain  (dirty_in),
    .dataout (dirty2_out)
  );

  array #(.width(TAG_WIDTH)) victim_tag (
    .clk     (clk),
    .reset   (1'b0),
    .write   (lru_load),
    .index   (index),
    .datain  (victim_tag_in),
    .dataout (victim_tag_out)
  );

  // ------------------------------
  // victim and memory side
  // ------------------------------
  assign dirty      = lru_out ? dirty2_out : dirty1_out;
  assign pmem_wdata = lru_out ? data2_out : data1_out;

  // writeback goes to the victim's line, a fill to the requested line
  assign pmem_address = address_sel ? {victim_tag_out, index, {OFFSET_WIDTH{1'b0}}}
                                    : {tag, index, {OFFSET_WIDTH{1'b0}}};

  // a line may live in only one way of its set
  assert property (@(posedge clk) disable iff (reset) !(hit1 && hit2));

endmodule : cache_datapath

//--- hdl/array.sv
module array #(
  parameter int width = 128
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                write,
  input  logic [lc3b_types::INDEX_WIDTH-1:0]  index,
  input  logic [width-1:0]                    datain,
  output logic [width-1:0]                    dataout
);
  import lc3b_types::*;

  logic [width-1:0] data [CACHE_SETS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < CACHE_SETS; i++) begin
        data[i] <= '0;
      end
    end else if (write) begin
      data[index] <= datain;
    end
  end

  // read is combinational so a hit answers in the same cycle
  assign dataout = data[index];

  // a write to an unknown set would corrupt an arbitrary entry
  assert property (@(posedge clk) disable iff (reset)
    write |-> !$isunknown(index));

endmodule : array

//--- hdl/lc3b_types.sv
package lc3b_types;

  // processor word, used for both addresses and data
  typedef logic [15:0] lc3b_word;

  // byte enable of a processor write, bit 0 is the low byte
  typedef logic [1:0] lc3b_mem_wmask;

  // one cache line, seen raw by memory and the arrays, or as words by the datapath
  typedef union packed {
    logic [127:0]      bits;
    lc3b_word [7:0]    words;
  } lc3b_c_line;

  // ------------------------------
  // cache geometry
  // ------------------------------
  localparam int CACHE_SETS   = 8;
  localparam int INDEX_WIDTH  = 3;
  localparam int TAG_WIDTH    = 9;
  localparam int OFFSET_WIDTH = 4;

  // memory model response delay in cycles
  localparam int MEM_DELAY = 3;

  // miss handling states
  localparam logic [1:0] CTRL_COMPARE   = 2'd0;
  localparam logic [1:0] CTRL_WRITEBACK = 2'd1;
  localparam logic [1:0] CTRL_ALLOCATE  = 2'd2;

endpackage : lc3b_types
